// File: logic/hdc_pkg.sv
package hdc_pkg;

    // hypervector and item memory sizing
    localparam int HV_WIDTH   = 32;
    localparam int ITEM_DEPTH = 512;
    localparam int ADDR_WIDTH = 9;

    // instruction argument field
    // item address or rotation amount
    localparam int ARG_WIDTH  = 10;
    // only the low bits of arg count for rotation
    localparam int ROT_WIDTH  = 5;

    typedef logic [HV_WIDTH-1:0]   hv_t;
    typedef logic [ADDR_WIDTH-1:0] item_addr_t;

    // 16 bit instruction word, top bit first
    typedef struct packed {
        // needs an item address
        logic                 addr_mode;
        // rotate operand left
        logic                 permute;
        // load or xor
        logic                 combine;
        // store, or wb.item with addr_mode
        logic                 emit;
        logic                 move;
        logic                 last;
        logic [ARG_WIDTH-1:0] arg;
    } instr_t;

    // decoded operation for the execute stage
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_LOAD  = 3'd1,
        OP_XOR   = 3'd2,
        OP_STORE = 3'd3,
        OP_MOVE  = 3'd4,
        OP_LAST  = 3'd5
    } op_t;

    typedef struct packed {
        op_t                  op;
        logic                 permute;
        logic [ROT_WIDTH-1:0] shift;
    } exec_cmd_t;

    // write-back of reg_b into the item memory
    typedef struct packed {
        logic       valid;
        item_addr_t addr;
    } wb_req_t;

    // random generation write from outside
    typedef struct packed {
        logic       valid;
        item_addr_t addr;
        hv_t        vector;
    } gen_req_t;

endpackage

// File: logic/item_memory.sv
`timescale 1ns/1ps

module item_memory (
    input  logic              clk,
    input  hdc_pkg::gen_req_t gen,
    input  hdc_pkg::wb_req_t  wb,
    input  hdc_pkg::hv_t      wb_data,
    input  hdc_pkg::item_addr_t rd_addr,
    output hdc_pkg::hv_t      rd_data
);

    import hdc_pkg::*;

    // hypervector storage, one entry per item
    hv_t mem [ITEM_DEPTH];

    // single write port
    // write-back beats a generation write in the same cycle
    always_ff @(posedge clk) begin
        if (wb.valid) begin
            mem[wb.addr] <= wb_data;
        end else if (gen.valid) begin
            mem[gen.addr] <= gen.vector;
        end
    end

    // read every cycle, whether used or not
    // old contents when reading the address being written
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               instr_valid,
    input  hdc_pkg::instr_t    instr,
    output hdc_pkg::wb_req_t   wb,
    output hdc_pkg::exec_cmd_t cmd
);

    import hdc_pkg::*;

    exec_cmd_t dec_cmd;
    wb_req_t   dec_wb;

    // fixed priority decode of the instruction bits
    always_comb begin
        dec_cmd = '0;
        dec_wb  = '0;
        if (instr.addr_mode && instr.emit) begin
            // wb.item never reaches the execute stage
            dec_wb.valid = 1'b1;
            dec_wb.addr  = instr.arg[ADDR_WIDTH-1:0];
        end else if (instr.addr_mode) begin
            // addressed group, only load defined
            if (instr.combine) begin
                dec_cmd.op = OP_LOAD;
            end
        end else begin
            if (instr.combine) begin
                dec_cmd.op = OP_XOR;
            end else if (instr.emit) begin
                dec_cmd.op = OP_STORE;
            end else if (instr.move) begin
                dec_cmd.op = OP_MOVE;
            end else if (instr.last) begin
                dec_cmd.op = OP_LAST;
            end
            // rotation only matters for xor, store and move
            if (instr.combine || instr.emit || instr.move) begin
                dec_cmd.permute = instr.permute;
                dec_cmd.shift   = instr.arg[ROT_WIDTH-1:0];
            end
        end
    end

    // one cycle decode stage
    // idle cycles and run low turn into nop
    always_ff @(posedge clk) begin
        if (!rst_n || !run || !instr_valid) begin
            cmd <= '0;
            wb  <= '0;
        end else begin
            cmd <= dec_cmd;
            wb  <= dec_wb;
        end
    end

endmodule

// File: logic/hv_exec.sv
`timescale 1ns/1ps

module hv_exec (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  hdc_pkg::exec_cmd_t cmd,
    input  hdc_pkg::hv_t       mem_data,
    output hdc_pkg::hv_t       wb_data,
    output logic               store,
    output hdc_pkg::hv_t       core_result,
    output logic               last
);

    import hdc_pkg::*;

    // reg_a is the xor partner, reg_b the accumulator
    hv_t reg_a;
    hv_t reg_b;

    // reg_b after optional rotation
    hv_t operand;
    logic [2*HV_WIDTH-1:0] rot_wide;

    // latched vector for the store pulse
    hv_t buff;

    // left rotation
    // upper half of the doubled vector after the shift
    always_comb begin
        rot_wide = {reg_b, reg_b} << cmd.shift;
        if (cmd.permute) begin
            operand = rot_wide[2*HV_WIDTH-1 -: HV_WIDTH];
        end else begin
            operand = reg_b;
        end
    end

    // operand registers
    // run low keeps their contents
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_a <= '0;
            reg_b <= '0;
        end else if (run) begin
            case (cmd.op)
                // mem_data was read one edge earlier
                OP_LOAD: reg_b <= mem_data;
                OP_XOR:  reg_b <= reg_a ^ operand;
                OP_MOVE: reg_a <= operand;
                default: begin
                end
            endcase
        end
    end

    // store pulse and sticky last
    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            store <= 1'b0;
            last  <= 1'b0;
        end else begin
            store <= (cmd.op == OP_STORE);
            // held until run drops
            if (cmd.op == OP_LAST) begin
                last <= 1'b1;
            end
        end
    end

    // store buffer, only read while store is high
    always_ff @(posedge clk) begin
        if (cmd.op == OP_STORE) begin
            buff <= operand;
        end
    end

    // wb.item writes reg_b without rotation
    assign wb_data = reg_b;

    // result bus is zero outside the store pulse
    assign core_result = store ? buff : '0;

endmodule

// File: logic/hdc_core.sv
`timescale 1ns/1ps

module hdc_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  hdc_pkg::gen_req_t gen,
    input  logic              instr_valid,
    input  hdc_pkg::instr_t   instr,
    output logic              store,
    output hdc_pkg::hv_t      core_result,
    output logic              last
);

    import hdc_pkg::*;

    // decode to memory and execute
    wb_req_t   wb_req;
    exec_cmd_t exec_cmd;

    // item read data into execute
    hv_t mem_rd_data;
    // reg_b back into the memory
    hv_t wb_data;

    // read address taken straight from the incoming word
    // so the entry is ready one edge later with the command
    item_memory u_item_memory (
        .clk     (clk),
        .gen     (gen),
        .wb      (wb_req),
        .wb_data (wb_data),
        .rd_addr (instr.arg[ADDR_WIDTH-1:0]),
        .rd_data (mem_rd_data)
    );

    instr_decode u_instr_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb_req),
        .cmd         (exec_cmd)
    );

    hv_exec u_hv_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .cmd         (exec_cmd),
        .mem_data    (mem_rd_data),
        .wb_data     (wb_data),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

endmodule

// File: verif/tb_hdc_checks.svh
`ifndef TB_HDC_CHECKS_SVH
`define TB_HDC_CHECKS_SVH

// totals over the whole trace
int check_count = 0;
int error_count = 0;

// test in progress
int    test_num = 0;
string test_name = "";
int    test_errors_at_start = 0;
int    test_count = 0;
int    failed_tests = 0;

// hypervector result compare
task automatic check_hv(input string sig, input hv_t expected, input hv_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR at %0t: %s expected %h, got %h", $time, sig, expected, actual);
    end
endtask

// single bit result compare
task automatic check_flag(input string sig, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR at %0t: %s expected %b, got %b", $time, sig, expected, actual);
    end
endtask

task automatic start_test(input int num, input string name);
    test_num             = num;
    test_name            = name;
    test_errors_at_start = error_count;
endtask

// one line for the test that just ended
task automatic finish_test();
    int errs;
    if (test_num != 0) begin
        errs = error_count - test_errors_at_start;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d mismatches", test_num, test_name, errs);
        end
    end
    test_num = 0;
endtask

`endif

// File: verif/tb_hdc_core.sv
`timescale 1ns/1ps

module tb_hdc_core;

    import hdc_pkg::*;

    `include "tb_hdc_checks.svh"

    localparam string TRACE_PATH = "verif/hdc_trace.txt";

    logic     clk;
    logic     rst_n;
    logic     run;
    gen_req_t gen;
    logic     instr_valid;
    instr_t   instr;
    logic     store;
    hv_t      core_result;
    logic     last;

    // whole trace, read before reset
    string trace_lines[$];
    // pending store pulses, falling edge index and vector
    int  exp_cyc[$];
    hv_t exp_vec[$];

    // falling edges since reset release
    int cyc = 0;
    int last_instr_cyc = 0;
    // watchdog
    int wd_cycles = 0;
    int cycle_limit = 0;

    hdc_core u_hdc_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .gen         (gen),
        .instr_valid (instr_valid),
        .instr       (instr),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // limit only armed once the trace length is known
    always @(posedge clk) begin
        wd_cycles++;
        if (cycle_limit > 0 && wd_cycles > cycle_limit) begin
            $display("timeout: trace not finished within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_trace(output bit ok);
        int    fd;
        int    n;
        string line;
        fd = $fopen(TRACE_PATH, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    trace_lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    // inputs at a falling edge, outputs checked at the next one
    task automatic drive_cycle(input logic run_v, input gen_req_t gen_v,
                               input logic valid_v, input instr_t instr_v);
        run         = run_v;
        gen         = gen_v;
        instr_valid = valid_v;
        instr       = instr_v;
        @(negedge clk);
        cyc++;
        // store may only pulse where a vector is due
        if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
            check_flag("store", 1'b1, store);
            check_hv("core_result", exp_vec[0], core_result);
            void'(exp_cyc.pop_front());
            void'(exp_vec.pop_front());
        end else begin
            check_flag("store", 1'b0, store);
            check_hv("core_result", '0, core_result);
        end
    endtask

    // idle until every expected pulse is seen
    task automatic drain_checks();
        while (exp_cyc.size() > 0) begin
            drive_cycle(1'b1, '0, 1'b0, '0);
        end
    endtask

    task automatic run_line(input string line);
        byte         kind;
        int          n;
        int          need;
        int          num;
        string       name;
        item_addr_t  addr;
        hv_t         vec;
        logic [15:0] word;
        logic        level;
        gen_req_t    g;
        kind = line.getc(0);
        n    = 0;
        need = 0;
        g    = '0;
        case (kind)
            "#", "\n", "\r": begin
            end
            "T": begin
                need = 2;
                n = $sscanf(line, "T %d %s", num, name);
                drain_checks();
                finish_test();
                start_test(num, name);
            end
            "G": begin
                need = 2;
                n = $sscanf(line, "G %h %h", addr, vec);
                g.valid  = 1'b1;
                g.addr   = addr;
                g.vector = vec;
                drive_cycle(1'b1, g, 1'b0, '0);
            end
            "I": begin
                need = 1;
                n = $sscanf(line, "I %h", word);
                drive_cycle(1'b1, '0, 1'b1, instr_t'(word));
                last_instr_cyc = cyc;
            end
            "R": begin
                drive_cycle(1'b0, '0, 1'b0, '0);
            end
            "S": begin
                need = 1;
                n = $sscanf(line, "S %h", vec);
                // pulse seen one falling edge after the store's own cycle
                exp_cyc.push_back(last_instr_cyc + 1);
                exp_vec.push_back(vec);
            end
            "L": begin
                need = 1;
                n = $sscanf(line, "L %h", level);
                check_flag("last", level, last);
            end
            default: begin
                error_count++;
                $display("unknown kind of trace line: %s", line);
            end
        endcase
        if (n != need) begin
            error_count++;
            $display("trace line with missing fields: %s", line);
        end
    endtask

    initial begin
        bit ok;
        rst_n       = 1'b0;
        run         = 1'b0;
        gen         = '0;
        instr_valid = 1'b0;
        instr       = '0;
        load_trace(ok);
        if (!ok) begin
            $display("could not open trace file %s", TRACE_PATH);
            $display("*** FAILED ***");
            $finish;
        end else begin
            cycle_limit = 4 * trace_lines.size() + 50;
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            foreach (trace_lines[i]) begin
                run_line(trace_lines[i]);
            end
            drain_checks();
            finish_test();
            $display("tests %0d, failed %0d, checks %0d, errors %0d",
                     test_count, failed_tests, check_count, error_count);
            if (error_count == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: verif/hdc_trace.txt
# T num name | G addr vector | I instr | R run low cycle | S store vector | L last level
# all fields hex except the test number, text after the fields is ignored
T 1 gen_load_store
G 010 A5A50F0F
G 011 3C3C1234
I A010 load 0x010
I 1000 store
S A5A50F0F
T 2 bind_xor
I A010 load 0x010
I 0800 move reg_b to reg_a
I A011 load 0x011
I 2000 xor
I 1000 store
S 99991D3B
T 3 permute
I 5004 store rotated left by 4
S 9991D3B9
I 5001 store rotated left by 1
S 33323A77
I 53FF store with arg 0x3ff, only 31 counts
S CCCC8E9D
I 4808 move rotated left by 8
I 2000 xor
I 1000 store
S 008426A2
T 4 writeback
I A011 load 0x011
I 2000 xor with reg_a
I 9020 wb.item to 0x020
I A010 load 0x010 in between
I A020 load 0x020
I 1000 store
S A52129AD
T 5 last_run_low
L 0
I 0400 last
I 0000 nop
I 0000 nop
L 1
R
L 0
I 1000 store of kept reg_b
S A52129AD
T 6 write_collision
I A010 load 0x010
I 9030 wb.item to 0x030
G 030 DEADBEEF lands on the write-back edge
I A011 load 0x011
I A030 load 0x030
I 1000 store
S A5A50F0F

// File: files.f
+incdir+verif
logic/hdc_pkg.sv
logic/item_memory.sv
logic/instr_decode.sv
logic/hv_exec.sv
logic/hdc_core.sv
verif/tb_hdc_core.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_hdc_core
RTL_TOP    := hdc_core
FILELIST   := files.f
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timescale 1ns/1ps -j 0
LOG        := sim.log
BIN        := obj_dir/V$(TOP)
SRCS       := $(wildcard logic/*.sv verif/*.sv verif/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
